// File: rtl/cache_pkg.sv
package cache_pkg;

    // Word address into the 4096-word backing memory
    typedef logic [11:0] addr_t;

    typedef logic [31:0] data_t;

    // 16 lines means a 4-bit index and an 8-bit tag
    localparam int LINES_DEFAULT = 16;

    // Generator reads fall in WINDOW_BASE .. WINDOW_BASE + 0xFF
    localparam addr_t WINDOW_BASE = 12'hA00;

    // Idle cycles between generator reads
    localparam int INTERVAL_DEFAULT = 10;

endpackage

// File: rtl/bus_pkg.sv
package bus_pkg;

    // Cache 0 (CPU) and cache 1 (generator) share the memory
    localparam int NUM_REQ = 2;

    // Bit i of the one-hot grant is set while requester i owns the memory
    typedef logic [NUM_REQ-1:0] grant_t;

    // Cycles from request sampled to acknowledge
    localparam int MEM_WAIT_DEFAULT = 3;

    localparam int MEM_WORDS = 4096;

endpackage

// File: rtl/read_traffic_gen.sv
`timescale 1ns/10ps

module read_traffic_gen #(
    parameter int INTERVAL = cache_pkg::INTERVAL_DEFAULT
) (
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic              gen_enable,
    input  logic              gen_ack,
    input  cache_pkg::data_t  gen_rdata,
    output logic              gen_req,
    output cache_pkg::addr_t  gen_addr,
    output logic [15:0]       gen_count,
    output cache_pkg::data_t  gen_sum
);

    import cache_pkg::*;

    localparam int CNT_W = $clog2(INTERVAL + 1);

    logic [CNT_W-1:0] interval_cnt;
    logic [7:0]       lfsr;
    logic             lfsr_fb;
    logic             idle;

    // Taps 8, 6, 5, 4
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // Nothing outstanding on the generator port
    assign idle = !gen_req && !gen_ack;

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            interval_cnt <= '0;
            lfsr         <= 8'h01;
            gen_req      <= 1'b0;
        end else begin
            if (idle && gen_enable) begin
                if (interval_cnt == CNT_W'(INTERVAL - 1)) begin
                    interval_cnt <= '0;
                    gen_req      <= 1'b1;
                    lfsr         <= {lfsr[6:0], lfsr_fb};
                end else begin
                    interval_cnt <= interval_cnt + 1'b1;
                end
            end else if (gen_req && gen_ack) begin
                gen_req <= 1'b0;
            end
        end
    end

    // Address uses the LFSR value before the advance
    always_ff @(posedge cpu_intf) begin
        if (idle && gen_enable && interval_cnt == CNT_W'(INTERVAL - 1)) begin
            gen_addr <= WINDOW_BASE + addr_t'(lfsr);
        end
    end

    // Running checksum of returned words
    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            gen_count <= '0;
            gen_sum   <= '0;
        end else if (gen_req && gen_ack) begin
            gen_count <= gen_count + 1'b1;
            gen_sum   <= gen_sum + gen_rdata;
        end
    end

endmodule

// File: rtl/read_cache.sv
`timescale 1ns/10ps

module read_cache #(
    parameter int LINES = cache_pkg::LINES_DEFAULT
) (
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic              req,
    input  cache_pkg::addr_t  addr,
    input  logic              mack,
    input  cache_pkg::data_t  mrdata,
    output logic              ack,
    output cache_pkg::data_t  rdata,
    output logic              mreq,
    output cache_pkg::addr_t  maddr,
    output logic [15:0]       hit_count,
    output logic [15:0]       miss_count
);

    import cache_pkg::*;

    localparam int ADDR_W = $bits(addr_t);
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - IDX_W;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_RESPOND,
        S_RELEASE
    } state_t;

    state_t           state;
    addr_t            addr_q;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;

    logic [TAG_W-1:0] tag_arr [LINES];
    data_t            data_arr [LINES];
    logic [LINES-1:0] valid;

    assign idx   = addr_q[IDX_W-1:0];
    assign tag   = addr_q[ADDR_W-1:IDX_W];
    assign hit   = valid[idx] && (tag_arr[idx] == tag);
    assign maddr = addr_q;

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            ack        <= 1'b0;
            mreq       <= 1'b0;
            valid      <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        hit_count <= hit_count + 1'b1;
                        state     <= S_RESPOND;
                    end else begin
                        miss_count <= miss_count + 1'b1;
                        mreq       <= 1'b1;
                        state      <= S_FILL;
                    end
                end
                S_FILL: begin
                    // Line is written on ack and the state is left once ack drops again
                    if (mreq && mack) begin
                        mreq       <= 1'b0;
                        valid[idx] <= 1'b1;
                    end else if (!mreq && !mack) begin
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    ack   <= 1'b1;
                    state <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request address is held for the whole transaction
    always_ff @(posedge cpu_intf) begin
        if (state == S_IDLE && req) begin
            addr_q <= addr;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (state == S_FILL && mreq && mack) begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= mrdata;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (state == S_LOOKUP && hit) begin
            rdata <= data_arr[idx];
        end else if (state == S_FILL && mreq && mack) begin
            rdata <= mrdata;
        end
    end

    // Requester must not move the address before the cache answers
    a_addr_stable: assert property (
        @(posedge cpu_intf) disable iff (!rst_n)
        (req && !ack) |=> (!req || ack || $stable(addr))
    ) else $error("read_cache: addr changed during open request");

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                                     cpu_intf,
    input  logic                                     rst_n,
    input  logic [bus_pkg::NUM_REQ-1:0]              mreq,
    input  cache_pkg::addr_t [bus_pkg::NUM_REQ-1:0]  maddr,
    input  logic                                     mem_ack,
    input  cache_pkg::data_t                         mem_rdata,
    output logic [bus_pkg::NUM_REQ-1:0]              mack,
    output cache_pkg::data_t                         mrdata,
    output logic                                     mem_req,
    output cache_pkg::addr_t                         mem_addr
);

    import bus_pkg::*;

    localparam int IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

    grant_t           grant;
    grant_t           next_grant;
    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] win_idx;
    logic             ack_seen;

    // Search starts just after the last winner
    always_comb begin
        int cand;
        next_grant = '0;
        win_idx    = last_q;
        for (int k = 1; k <= NUM_REQ; k++) begin
            cand = (int'(last_q) + k) % NUM_REQ;
            if (next_grant == '0 && mreq[cand]) begin
                next_grant[cand] = 1'b1;
                win_idx          = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            grant    <= '0;
            last_q   <= '0;
            ack_seen <= 1'b0;
        end else if (grant == '0) begin
            if (!mem_ack && next_grant != '0) begin
                grant    <= next_grant;
                last_q   <= win_idx;
                ack_seen <= 1'b0;
            end
        end else begin
            // Release only after the memory has dropped its ack
            if (mem_ack) begin
                ack_seen <= 1'b1;
            end else if (ack_seen) begin
                grant    <= '0;
                ack_seen <= 1'b0;
            end
        end
    end

    assign mem_req  = |(mreq & grant);
    assign mem_addr = maddr[last_q];
    assign mack     = grant & {NUM_REQ{mem_ack}};
    assign mrdata   = mem_rdata;

    // Grant stays put while a memory transaction is open
    a_grant_held: assert property (
        @(posedge cpu_intf) disable iff (!rst_n)
        (mem_req || mem_ack) |=> $stable(grant)
    ) else $error("mem_arbiter: grant changed during an open memory transaction");

endmodule

// File: rtl/backing_mem.sv
`timescale 1ns/10ps

module backing_mem #(
    parameter int MEM_WAIT = bus_pkg::MEM_WAIT_DEFAULT
) (
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic              mem_req,
    input  cache_pkg::addr_t  mem_addr,
    input  logic              load_en,
    input  cache_pkg::addr_t  load_addr,
    input  cache_pkg::data_t  load_data,
    output logic              mem_ack,
    output cache_pkg::data_t  mem_rdata
);

    import cache_pkg::*;
    import bus_pkg::*;

    localparam int WAIT_W = $clog2(MEM_WAIT + 1);

    data_t             mem [MEM_WORDS];
    logic [WAIT_W-1:0] wait_cnt;

    always_ff @(posedge cpu_intf) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            mem_ack  <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (wait_cnt == WAIT_W'(MEM_WAIT - 1)) begin
                wait_cnt <= '0;
                mem_ack  <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end else if (!mem_req) begin
            mem_ack <= 1'b0;
        end
    end

    // Data appears together with the ack
    always_ff @(posedge cpu_intf) begin
        if (mem_req && !mem_ack && wait_cnt == WAIT_W'(MEM_WAIT - 1)) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

// File: rtl/cache_subsys_top.sv
`timescale 1ns/10ps

module cache_subsys_top #(
    parameter int INTERVAL = cache_pkg::INTERVAL_DEFAULT,
    parameter int LINES    = cache_pkg::LINES_DEFAULT,
    parameter int MEM_WAIT = bus_pkg::MEM_WAIT_DEFAULT
) (
    input  logic              cpu_intf,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  cache_pkg::addr_t  cpu_addr,
    input  logic              load_en,
    input  cache_pkg::addr_t  load_addr,
    input  cache_pkg::data_t  load_data,
    input  logic              gen_enable,
    output logic              cpu_ack,
    output cache_pkg::data_t  cpu_rdata,
    output logic [15:0]       hit_count,
    output logic [15:0]       miss_count,
    output logic [15:0]       gen_count,
    output cache_pkg::data_t  gen_sum
);

    import cache_pkg::*;
    import bus_pkg::*;

    logic                       gen_req;
    addr_t                      gen_addr;
    logic                       gen_ack;
    data_t                      gen_rdata;

    // Index 0 is the CPU cache, index 1 the generator cache
    logic [NUM_REQ-1:0]         mreq;
    addr_t [NUM_REQ-1:0]        maddr;
    logic [NUM_REQ-1:0]         mack;
    data_t                      mrdata;

    logic                       mem_req;
    addr_t                      mem_addr;
    logic                       mem_ack;
    data_t                      mem_rdata;

    read_traffic_gen #(
        .INTERVAL (INTERVAL)
    ) u_gen (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .gen_enable (gen_enable),
        .gen_ack    (gen_ack),
        .gen_rdata  (gen_rdata),
        .gen_req    (gen_req),
        .gen_addr   (gen_addr),
        .gen_count  (gen_count),
        .gen_sum    (gen_sum)
    );

    read_cache #(
        .LINES (LINES)
    ) u_cpu_cache (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .req        (cpu_req),
        .addr       (cpu_addr),
        .mack       (mack[0]),
        .mrdata     (mrdata),
        .ack        (cpu_ack),
        .rdata      (cpu_rdata),
        .mreq       (mreq[0]),
        .maddr      (maddr[0]),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    read_cache #(
        .LINES (LINES)
    ) u_gen_cache (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .req        (gen_req),
        .addr       (gen_addr),
        .mack       (mack[1]),
        .mrdata     (mrdata),
        .ack        (gen_ack),
        .rdata      (gen_rdata),
        .mreq       (mreq[1]),
        .maddr      (maddr[1]),
        .hit_count  (),
        .miss_count ()
    );

    mem_arbiter u_arb (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .mreq      (mreq),
        .maddr     (maddr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mack      (mack),
        .mrdata    (mrdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr)
    );

    backing_mem #(
        .MEM_WAIT (MEM_WAIT)
    ) u_mem (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: tests/read_vectors.svh
// Each entry holds the test group in [16:13], the CPU word address in [12:1]
// and the expected hit in [0]
// Group 1 cold misses, 2 hits, 3 conflict eviction, 5 reads under generator traffic

localparam int NUM_VECTORS = 25;

logic [16:0] vectors [NUM_VECTORS] = '{
    {4'd1, 12'h100, 1'b0},
    {4'd1, 12'h211, 1'b0},
    {4'd1, 12'h322, 1'b0},
    {4'd1, 12'h433, 1'b0},
    {4'd1, 12'h544, 1'b0},
    {4'd1, 12'h655, 1'b0},
    {4'd2, 12'h100, 1'b1},
    {4'd2, 12'h211, 1'b1},
    {4'd2, 12'h322, 1'b1},
    {4'd2, 12'h433, 1'b1},
    {4'd2, 12'h544, 1'b1},
    {4'd2, 12'h655, 1'b1},
    // Index 7 with three different tags
    {4'd3, 12'h107, 1'b0},
    {4'd3, 12'h207, 1'b0},
    {4'd3, 12'h107, 1'b0},
    {4'd3, 12'h207, 1'b0},
    {4'd3, 12'h307, 1'b0},
    {4'd5, 12'h0A8, 1'b0},
    {4'd5, 12'h0A8, 1'b1},
    {4'd5, 12'h1A9, 1'b0},
    {4'd5, 12'hA0A, 1'b0},
    {4'd5, 12'h1A9, 1'b1},
    {4'd5, 12'h100, 1'b1},
    {4'd5, 12'h2A8, 1'b0},
    {4'd5, 12'h0A8, 1'b0}
};

// File: tests/cache_subsys_tb.sv
`timescale 1ns/10ps

module cache_subsys_tb;

    import cache_pkg::*;
    import bus_pkg::*;

    localparam int INTERVAL = 10;
    localparam int LINES    = 16;
    localparam int MEM_WAIT = 3;

    localparam int GEN_TARGET = 40;

    `include "read_vectors.svh"

    // Worst read covers a full memory transaction of the other cache first
    localparam int READ_WORST  = 4 * MEM_WAIT + 20;
    localparam int GEN_READS   = GEN_TARGET + NUM_VECTORS;
    localparam int CYCLE_LIMIT = MEM_WORDS + NUM_VECTORS * READ_WORST
                               + GEN_READS * (INTERVAL + READ_WORST) + 500;

    logic        cpu_intf;
    logic        rst_n;
    logic        cpu_req;
    addr_t       cpu_addr;
    logic        load_en;
    addr_t       load_addr;
    data_t       load_data;
    logic        gen_enable;
    logic        cpu_ack;
    data_t       cpu_rdata;
    logic [15:0] hit_count;
    logic [15:0] miss_count;
    logic [15:0] gen_count;
    data_t       gen_sum;

    data_t       model_mem [MEM_WORDS];
    integer      seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    logic [15:0] exp_hits;
    logic [15:0] exp_misses;

    cache_subsys_top #(
        .INTERVAL (INTERVAL),
        .LINES    (LINES),
        .MEM_WAIT (MEM_WAIT)
    ) DUT (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .gen_enable (gen_enable),
        .cpu_ack    (cpu_ack),
        .cpu_rdata  (cpu_rdata),
        .hit_count  (hit_count),
        .miss_count (miss_count),
        .gen_count  (gen_count),
        .gen_sum    (gen_sum)
    );

    initial begin
        cpu_intf = 1'b0;
        forever #4 cpu_intf = ~cpu_intf;
    end

    always @(posedge cpu_intf) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles with tests unfinished", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Expected checksum over the first n generator addresses
    function automatic data_t gen_model_sum(input int n);
        logic [7:0] lfsr;
        data_t      sum;
        addr_t      a;
        lfsr = 8'h01;
        sum  = '0;
        for (int i = 0; i < n; i++) begin
            a    = 12'hA00 + {4'h0, lfsr};
            sum  = sum + model_mem[a];
            lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
        return sum;
    endfunction

    task automatic preload_memory;
        for (int i = 0; i < MEM_WORDS; i++) begin
            load_en      = 1'b1;
            load_addr    = addr_t'(i);
            load_data    = $random(seed);
            model_mem[i] = load_data;
            @(posedge cpu_intf);
            #1;
        end
        load_en = 1'b0;
    endtask

    // Four-phase read on the CPU port
    task automatic cpu_read(input addr_t a, output data_t d);
        cpu_addr = a;
        cpu_req  = 1'b1;
        do begin
            @(posedge cpu_intf);
            #1;
        end while (!cpu_ack);
        d       = cpu_rdata;
        cpu_req = 1'b0;
        do begin
            @(posedge cpu_intf);
            #1;
        end while (cpu_ack);
    endtask

    task automatic apply_group(input int group);
        addr_t a;
        logic  exp_hit;
        data_t d;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (int'(vectors[i][16:13]) == group) begin
                a       = vectors[i][12:1];
                exp_hit = vectors[i][0];
                if (exp_hit) begin
                    exp_hits = exp_hits + 1'b1;
                end else begin
                    exp_misses = exp_misses + 1'b1;
                end
                cpu_read(a, d);
                if (d !== model_mem[a]) begin
                    $display("error at %0t: read of 0x%03h returned 0x%08h, expected 0x%08h",
                             $time, a, d, model_mem[a]);
                    errors++;
                end
                if (hit_count !== exp_hits) begin
                    $display("error at %0t: after 0x%03h hit_count is %0d, expected %0d",
                             $time, a, hit_count, exp_hits);
                    errors++;
                end
                if (miss_count !== exp_misses) begin
                    $display("error at %0t: after 0x%03h miss_count is %0d, expected %0d",
                             $time, a, miss_count, exp_misses);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    task automatic run_group(input int group, input string name);
        int err_before;
        err_before = errors;
        apply_group(group);
        report_test(name, err_before);
    endtask

    task automatic check_generator;
        int    err_before;
        data_t exp_sum;
        err_before = errors;
        gen_enable = 1'b1;
        while (gen_count < 16'(GEN_TARGET)) begin
            @(posedge cpu_intf);
            #1;
        end
        gen_enable = 1'b0;
        exp_sum    = gen_model_sum(GEN_TARGET);
        if (gen_count !== 16'(GEN_TARGET)) begin
            $display("error at %0t: gen_count is %0d, expected %0d",
                     $time, gen_count, GEN_TARGET);
            errors++;
        end
        if (gen_sum !== exp_sum) begin
            $display("error at %0t: gen_sum is 0x%08h, expected 0x%08h",
                     $time, gen_sum, exp_sum);
            errors++;
        end
        report_test("generator checksum", err_before);
    endtask

    task automatic run_contention;
        int          err_before;
        logic [15:0] count_start;
        logic [15:0] count_prev;
        data_t       exp_sum;
        err_before  = errors;
        count_start = gen_count;
        gen_enable  = 1'b1;
        apply_group(5);
        // Stop right after a generator read completes, so none is left open
        count_prev = gen_count;
        while (gen_count == count_prev) begin
            @(posedge cpu_intf);
            #1;
        end
        gen_enable = 1'b0;
        if (gen_count <= count_start + 16'd1) begin
            $display("generator made too few reads while the CPU port was busy");
            errors++;
        end
        exp_sum = gen_model_sum(int'(gen_count));
        if (gen_sum !== exp_sum) begin
            $display("error at %0t: gen_sum after %0d reads is 0x%08h, expected 0x%08h",
                     $time, gen_count, gen_sum, exp_sum);
            errors++;
        end
        report_test("shared memory under contention", err_before);
    endtask

    initial begin
        rst_n        = 1'b0;
        cpu_req      = 1'b0;
        cpu_addr     = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        gen_enable   = 1'b0;
        seed         = 32'h6d4105d4;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        exp_hits     = '0;
        exp_misses   = '0;

        repeat (2) @(posedge cpu_intf);
        #1;
        rst_n = 1'b1;

        preload_memory();
        run_group(1, "cold misses");
        run_group(2, "hits");
        run_group(3, "conflict eviction");
        check_generator();
        run_contention();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+tests
rtl/cache_pkg.sv
rtl/bus_pkg.sv
rtl/read_traffic_gen.sv
rtl/read_cache.sv
rtl/mem_arbiter.sv
rtl/backing_mem.sv
rtl/cache_subsys_top.sv
tests/cache_subsys_tb.sv
